//--- sources.f
source/vbus_pkg.sv
source/main_ram.sv
source/lane_ram.sv
source/membus_arbiter.sv
source/regbus_ctrl.sv
source/vbus_top.sv
tests/tb_vbus.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the vbus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_vbus
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_vbus)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

//--- tests/vbus_cases.txt
// op(1 write, 2 read, 3 palette display, 4 sprite display, 5 fetch)_addr_data_expected
// addr is a register address, or an entry index for ops 3 and 4
1_00010_000000a5_00000000
1_00013_0000003c_00000000
2_00010_00000000_000000a5
2_00011_00000000_00000000
2_00013_00000000_0000003c
1_1fffe_0000005a_00000000
2_1fffe_00000000_0000005a
1_40206_000000bc_00000000
1_40207_0000000a_00000000
2_40206_00000000_000000bc
2_40207_00000000_0000000a
3_00003_00000000_00000abc
1_40814_00000011_00000000
1_40815_00000022_00000000
1_40816_00000033_00000000
1_40817_00000044_00000000
4_00005_00000000_44332211
2_40816_00000000_00000033
1_40000_000000ff_00000000
2_40000_00000000_00000000
2_40100_00000000_00000000
5_00010_00000000_000000a5
5_1fffe_00000000_0000005a

//--- tests/tb_vbus.sv
`default_nettype none

module tb_vbus;

    timeunit 1ns;
    timeprecision 100ps;

    logic                     clk;
    logic                     reset;
    logic                     req_valid;
    vbus_pkg::host_req_t      req;
    logic                     req_ready;
    logic                     rsp_valid;
    vbus_pkg::byte_t          rsp_data;
    logic                     rsp_ready;
    logic                     lyr_valid;
    vbus_pkg::ram_word_addr_t lyr_addr;
    logic                     lyr_ready;
    logic                     lyr_ack;
    vbus_pkg::word_t          lyr_data;
    logic                     spr_valid;
    vbus_pkg::ram_word_addr_t spr_addr;
    logic                     spr_ready;
    logic                     spr_ack;
    vbus_pkg::word_t          spr_data;
    vbus_pkg::pal_idx_t       pal_idx;
    vbus_pkg::pal_entry_t     pal_rgb;
    vbus_pkg::spr_idx_t       spr_idx;
    vbus_pkg::spr_attr_t      spr_attr;

    logic [87:0]     case_mem [0:63];
    vbus_pkg::byte_t main_model [0:(1 << 17) - 1];
    vbus_pkg::byte_t pal_model [0:511];
    vbus_pkg::byte_t spr_model [0:1023];
    int              mismatch_count = 0;
    int              other_count    = 0;
    int              cycle_count    = 0;
    int              cycle_limit    = 200;

    vbus_top u_vbus_top (
        .clk (clk), .reset (reset),
        .req_valid_i (req_valid), .req_i (req), .req_ready_o (req_ready),
        .rsp_valid_o (rsp_valid), .rsp_data_o (rsp_data), .rsp_ready_i (rsp_ready),
        .lyr_fetch_valid_i (lyr_valid), .lyr_fetch_addr_i (lyr_addr),
        .lyr_fetch_ready_o (lyr_ready), .lyr_fetch_ack_o (lyr_ack),
        .lyr_fetch_data_o (lyr_data),
        .spr_fetch_valid_i (spr_valid), .spr_fetch_addr_i (spr_addr),
        .spr_fetch_ready_o (spr_ready), .spr_fetch_ack_o (spr_ack),
        .spr_fetch_data_o (spr_data),
        .pal_idx_i (pal_idx), .pal_rgb_o (pal_rgb),
        .spr_idx_i (spr_idx), .spr_attr_o (spr_attr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit from the number of case lines
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, a handshake never completed", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model of the memory map
    ////////////////////////////////////////////////////////////
    function automatic vbus_pkg::region_e region_of(input vbus_pkg::reg_addr_t a);
        if (!a[vbus_pkg::MAIN_BASE_BIT]) begin
            return vbus_pkg::REGION_MAIN;
        end
        if (a >= vbus_pkg::PAL_BASE &&
            a < vbus_pkg::PAL_BASE + (1 << vbus_pkg::PAL_SPAN_BITS)) begin
            return vbus_pkg::REGION_PALETTE;
        end
        if (a >= vbus_pkg::SPR_BASE &&
            a < vbus_pkg::SPR_BASE + (1 << vbus_pkg::SPR_SPAN_BITS)) begin
            return vbus_pkg::REGION_SPRITE;
        end
        return vbus_pkg::REGION_NONE;
    endfunction

    function automatic vbus_pkg::byte_t model_read(input vbus_pkg::reg_addr_t a);
        case (region_of(a))
            vbus_pkg::REGION_MAIN:    return main_model[a[16:0]];
            vbus_pkg::REGION_PALETTE: return pal_model[a[8:0]];
            vbus_pkg::REGION_SPRITE:  return spr_model[a[9:0]];
            default:                  return 8'h00;
        endcase
    endfunction

    function automatic vbus_pkg::word_t model_word(input vbus_pkg::ram_word_addr_t w);
        return {main_model[{w, 2'd3}], main_model[{w, 2'd2}],
                main_model[{w, 2'd1}], main_model[{w, 2'd0}]};
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks and failure reports
    ////////////////////////////////////////////////////////////
    task automatic check_byte(input string name, input vbus_pkg::byte_t got,
                              input vbus_pkg::byte_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_word(input string name, input vbus_pkg::word_t got,
                              input vbus_pkg::word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_pal(input string name, input vbus_pkg::pal_entry_t got,
                             input vbus_pkg::pal_entry_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_attr(input string name, input vbus_pkg::spr_attr_t got,
                              input vbus_pkg::spr_attr_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("error at %0d ns: %s", $time, what);
        other_count++;
    endtask

    // Arbitration rules sampled mid-cycle when inputs are settled
    always @(negedge clk) begin
        if (!reset) begin
            if (req_valid && req_ready && region_of(req.addr) == vbus_pkg::REGION_MAIN &&
                lyr_valid && lyr_ready) begin
                report_failure("layer fetch accepted together with a host main RAM request");
            end
            if (spr_valid && spr_ready && lyr_valid) begin
                report_failure("sprite fetch accepted while layer fetch valid is high");
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Bus tasks start and end 10 ns after a rising edge
    ////////////////////////////////////////////////////////////
    task automatic host_send(input vbus_pkg::reg_addr_t a, input vbus_pkg::byte_t d,
                             input logic wr);
        logic rdy;
        req_valid  = 1'b1;
        req.addr   = a;
        req.wdata  = d;
        req.write  = wr;
        do begin
            @(negedge clk);
            rdy = req_ready;
            @(posedge clk);
            #10;
        end while (!rdy);
        req_valid = 1'b0;
    endtask

    task automatic host_read(input vbus_pkg::reg_addr_t a, output vbus_pkg::byte_t result);
        logic seen;
        logic done;
        seen = 1'b0;
        done = 1'b0;
        host_send(a, 8'h00, 1'b0);
        while (!done) begin
            // Random stalls on the response
            rsp_ready = ($urandom % 3 == 0);
            @(negedge clk);
            if (req_ready) begin
                report_failure("req_ready_o high while a read is pending");
            end
            if (rsp_valid) begin
                if (!seen) begin
                    result = rsp_data;
                    seen   = 1'b1;
                end else begin
                    check_byte("rsp_data_o (held)", rsp_data, result);
                end
                done = rsp_ready;
            end
            @(posedge clk);
            #10;
        end
        rsp_ready = 1'b0;
    endtask

    task automatic fetch_word(input logic sprite_port, input vbus_pkg::ram_word_addr_t w);
        logic rdy;
        if (sprite_port) begin
            spr_valid = 1'b1;
            spr_addr  = w;
        end else begin
            lyr_valid = 1'b1;
            lyr_addr  = w;
        end
        do begin
            @(negedge clk);
            rdy = sprite_port ? spr_ready : lyr_ready;
            @(posedge clk);
            #10;
        end while (!rdy);
        if (sprite_port) begin
            spr_valid = 1'b0;
        end else begin
            lyr_valid = 1'b0;
        end
        @(negedge clk);
        if (sprite_port) begin
            if (!spr_ack) report_failure("no sprite fetch ack one cycle after acceptance");
            check_word("spr_fetch_data_o", spr_data, model_word(w));
        end else begin
            if (!lyr_ack) report_failure("no layer fetch ack one cycle after acceptance");
            check_word("lyr_fetch_data_o", lyr_data, model_word(w));
        end
        @(posedge clk);
        #10;
    endtask

    task automatic expect_model(input vbus_pkg::reg_addr_t a, input vbus_pkg::byte_t exp);
        if (model_read(a) !== exp) begin
            report_failure($sformatf("case file expects %h at %h, model holds %h",
                                     exp, a, model_read(a)));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int                       n_cases;
        int                       seed_init;
        logic [3:0]               op;
        vbus_pkg::reg_addr_t      addr;
        vbus_pkg::byte_t          data;
        vbus_pkg::word_t          exp;
        vbus_pkg::byte_t          got;
        vbus_pkg::ram_word_addr_t fa_lyr;
        vbus_pkg::ram_word_addr_t fa_spr;

        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        lyr_valid = 1'b0;
        lyr_addr  = '0;
        spr_valid = 1'b0;
        spr_addr  = '0;
        pal_idx   = '0;
        spr_idx   = '0;
        seed_init = $urandom(32'h5274_fb6b);

        for (int i = 0; i < (1 << 17); i++) main_model[i] = 8'h00;
        for (int i = 0; i < 512; i++) pal_model[i] = 8'h00;
        for (int i = 0; i < 1024; i++) spr_model[i] = 8'h00;

        // Unused entries keep op F as an end marker
        for (int i = 0; i < 64; i++) case_mem[i] = '1;
        $readmemh("tests/vbus_cases.txt", case_mem);
        n_cases = 0;
        while (n_cases < 64 && case_mem[n_cases][87:84] != 4'hF) n_cases++;
        cycle_limit = 40 * n_cases + 200;
        if (n_cases == 0) report_failure("no case lines read from tests/vbus_cases.txt");

        repeat (16) @(posedge clk);
        #10;
        reset = 1'b0;
        @(negedge clk);
        if (!req_ready || rsp_valid || lyr_ack || spr_ack) begin
            report_failure("handshake outputs not at their idle values after reset");
        end
        @(posedge clk);
        #10;

        for (int i = 0; i < n_cases; i++) begin
            op   = case_mem[i][87:84];
            addr = case_mem[i][82:64];
            data = case_mem[i][39:32];
            exp  = case_mem[i][31:0];
            case (op)
                4'h1: begin
                    host_send(addr, data, 1'b1);
                    case (region_of(addr))
                        vbus_pkg::REGION_MAIN:    main_model[addr[16:0]] = data;
                        vbus_pkg::REGION_PALETTE: pal_model[addr[8:0]] = data;
                        vbus_pkg::REGION_SPRITE:  spr_model[addr[9:0]] = data;
                        default: ;
                    endcase
                end
                4'h2: begin
                    host_read(addr, got);
                    check_byte("rsp_data_o", got, exp[7:0]);
                    expect_model(addr, exp[7:0]);
                end
                4'h3: begin
                    pal_idx = addr[7:0];
                    @(posedge clk);
                    @(negedge clk);
                    check_pal("pal_rgb_o", pal_rgb, exp[15:0]);
                    expect_model(vbus_pkg::PAL_BASE + {addr[7:0], 1'b0}, exp[7:0]);
                    expect_model(vbus_pkg::PAL_BASE + {addr[7:0], 1'b1}, exp[15:8]);
                    @(posedge clk);
                    #10;
                end
                4'h4: begin
                    spr_idx = addr[7:0];
                    @(posedge clk);
                    @(negedge clk);
                    check_attr("spr_attr_o", spr_attr, exp);
                    for (int b = 0; b < 4; b++) begin
                        expect_model(vbus_pkg::SPR_BASE + {addr[7:0], 2'(b)}, exp[8*b +: 8]);
                    end
                    @(posedge clk);
                    #10;
                end
                4'h5: begin
                    // Host read contends with both fetch ports
                    fa_lyr = addr[16:2] + vbus_pkg::ram_word_addr_t'($urandom % 2);
                    fa_spr = addr[16:2] + vbus_pkg::ram_word_addr_t'($urandom % 4);
                    fork
                        host_read(addr, got);
                        fetch_word(1'b0, fa_lyr);
                        fetch_word(1'b1, fa_spr);
                    join
                    check_byte("rsp_data_o", got, exp[7:0]);
                    expect_model(addr, exp[7:0]);
                end
                default: report_failure($sformatf("unknown operation %h on case line %0d", op, i));
            endcase
        end

        @(posedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/vbus_top.sv
`default_nettype none

module vbus_top (
    input  wire                        clk,
    input  wire                        reset,

    // Host register port
    input  wire                        req_valid_i,
    input  wire vbus_pkg::host_req_t   req_i,
    output logic                       req_ready_o,
    output logic                       rsp_valid_o,
    output vbus_pkg::byte_t            rsp_data_o,
    input  wire                        rsp_ready_i,

    // Layer fetch port
    input  wire                        lyr_fetch_valid_i,
    input  wire vbus_pkg::ram_word_addr_t lyr_fetch_addr_i,
    output logic                       lyr_fetch_ready_o,
    output logic                       lyr_fetch_ack_o,
    output vbus_pkg::word_t            lyr_fetch_data_o,

    // Sprite fetch port
    input  wire                        spr_fetch_valid_i,
    input  wire vbus_pkg::ram_word_addr_t spr_fetch_addr_i,
    output logic                       spr_fetch_ready_o,
    output logic                       spr_fetch_ack_o,
    output vbus_pkg::word_t            spr_fetch_data_o,

    // Display side reads
    input  wire vbus_pkg::pal_idx_t    pal_idx_i,
    output vbus_pkg::pal_entry_t       pal_rgb_o,
    input  wire vbus_pkg::spr_idx_t    spr_idx_i,
    output vbus_pkg::spr_attr_t        spr_attr_o
);

    logic                 host_cmd_valid;
    vbus_pkg::mem_cmd_t   host_cmd;
    vbus_pkg::mem_cmd_t   mem_cmd;
    vbus_pkg::word_t      main_rdata;
    vbus_pkg::word_t      fetch_data;
    vbus_pkg::pal_entry_t pal_rdata;
    vbus_pkg::spr_attr_t  spr_rdata;
    logic                 pal_we;
    logic                 spr_we;
    logic [1:0]           lane;
    logic [7:0]           word_idx;

    regbus_ctrl u_ctrl (
        .clk              (clk),
        .reset            (reset),
        .req_valid_i      (req_valid_i),
        .req_i            (req_i),
        .rsp_ready_i      (rsp_ready_i),
        .main_rdata_i     (main_rdata),
        .pal_rdata_i      (pal_rdata),
        .spr_rdata_i      (spr_rdata),
        .req_ready_o      (req_ready_o),
        .rsp_valid_o      (rsp_valid_o),
        .rsp_data_o       (rsp_data_o),
        .host_cmd_valid_o (host_cmd_valid),
        .host_cmd_o       (host_cmd),
        .pal_we_o         (pal_we),
        .spr_we_o         (spr_we),
        .lane_o           (lane),
        .word_idx_o       (word_idx)
    );

    membus_arbiter u_arb (
        .clk               (clk),
        .reset             (reset),
        .host_cmd_valid_i  (host_cmd_valid),
        .host_cmd_i        (host_cmd),
        .lyr_fetch_valid_i (lyr_fetch_valid_i),
        .lyr_fetch_addr_i  (lyr_fetch_addr_i),
        .spr_fetch_valid_i (spr_fetch_valid_i),
        .spr_fetch_addr_i  (spr_fetch_addr_i),
        .mem_rdata_i       (main_rdata),
        .lyr_fetch_ready_o (lyr_fetch_ready_o),
        .spr_fetch_ready_o (spr_fetch_ready_o),
        .lyr_fetch_ack_o   (lyr_fetch_ack_o),
        .spr_fetch_ack_o   (spr_fetch_ack_o),
        .fetch_data_o      (fetch_data),
        .mem_cmd_o         (mem_cmd)
    );

    // Both fetchers see the same returned word
    assign lyr_fetch_data_o = fetch_data;
    assign spr_fetch_data_o = fetch_data;

    main_ram u_main_ram (
        .clk     (clk),
        .cmd_i   (mem_cmd),
        .rdata_o (main_rdata)
    );

    lane_ram #(
        .LANES    (vbus_pkg::PAL_LANES),
        .IDX_BITS ($bits(vbus_pkg::pal_idx_t))
    ) u_pal_ram (
        .clk          (clk),
        .we_i         (pal_we),
        .lane_i       (lane[0]),
        .wr_idx_i     (word_idx),
        .wr_byte_i    (req_i.wdata),
        .host_rdata_o (pal_rdata),
        .disp_idx_i   (pal_idx_i),
        .disp_rdata_o (pal_rgb_o)
    );

    lane_ram #(
        .LANES    (vbus_pkg::SPR_LANES),
        .IDX_BITS ($bits(vbus_pkg::spr_idx_t))
    ) u_spr_ram (
        .clk          (clk),
        .we_i         (spr_we),
        .lane_i       (lane),
        .wr_idx_i     (word_idx),
        .wr_byte_i    (req_i.wdata),
        .host_rdata_o (spr_rdata),
        .disp_idx_i   (spr_idx_i),
        .disp_rdata_o (spr_attr_o)
    );

endmodule

`default_nettype wire

//--- source/regbus_ctrl.sv
`default_nettype none

module regbus_ctrl (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        req_valid_i,
    input  wire vbus_pkg::host_req_t   req_i,
    input  wire                        rsp_ready_i,
    input  wire vbus_pkg::word_t       main_rdata_i,
    input  wire vbus_pkg::pal_entry_t  pal_rdata_i,
    input  wire vbus_pkg::spr_attr_t   spr_rdata_i,
    output logic                       req_ready_o,
    output logic                       rsp_valid_o,
    output vbus_pkg::byte_t            rsp_data_o,
    output logic                       host_cmd_valid_o,
    output vbus_pkg::mem_cmd_t         host_cmd_o,
    output logic                       pal_we_o,
    output logic                       spr_we_o,
    output logic [1:0]                 lane_o,
    output logic [7:0]                 word_idx_o
);

    vbus_pkg::ctrl_state_e state_r;
    vbus_pkg::region_e     region;
    vbus_pkg::region_e     rd_region_r;
    logic [1:0]            rd_lane_r;
    vbus_pkg::byte_t       rd_byte;
    vbus_pkg::byte_t       rsp_data_r;
    logic                  accept;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        region     = vbus_pkg::REGION_NONE;
        lane_o     = req_i.addr[1:0];
        word_idx_o = req_i.addr[vbus_pkg::SPR_SPAN_BITS-1:2];
        if (!req_i.addr[vbus_pkg::MAIN_BASE_BIT]) begin
            region = vbus_pkg::REGION_MAIN;
        end else if ((req_i.addr >> vbus_pkg::PAL_SPAN_BITS) ==
                     (vbus_pkg::PAL_BASE >> vbus_pkg::PAL_SPAN_BITS)) begin
            // Palette entries are 16 bits, so only bit 0 picks the lane
            region     = vbus_pkg::REGION_PALETTE;
            lane_o     = {1'b0, req_i.addr[0]};
            word_idx_o = req_i.addr[vbus_pkg::PAL_SPAN_BITS-1:1];
        end else if ((req_i.addr >> vbus_pkg::SPR_SPAN_BITS) ==
                     (vbus_pkg::SPR_BASE >> vbus_pkg::SPR_SPAN_BITS)) begin
            region = vbus_pkg::REGION_SPRITE;
        end
    end

    assign req_ready_o = (state_r == vbus_pkg::ST_IDLE);
    assign accept      = req_valid_i && req_ready_o;

    // Main RAM command, byte replicated over all lanes
    assign host_cmd_valid_o  = accept && (region == vbus_pkg::REGION_MAIN);
    assign host_cmd_o.addr   = req_i.addr[16:2];
    assign host_cmd_o.wdata  = {4{req_i.wdata}};
    assign host_cmd_o.lanes  = 4'b0001 << req_i.addr[1:0];
    assign host_cmd_o.write  = req_i.write;

    assign pal_we_o = accept && req_i.write && (region == vbus_pkg::REGION_PALETTE);
    assign spr_we_o = accept && req_i.write && (region == vbus_pkg::REGION_SPRITE);

    ////////////////////////////////////////////////////////////
    // Read response
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (rd_region_r)
            vbus_pkg::REGION_MAIN:    rd_byte = main_rdata_i[{rd_lane_r, 3'b000} +: 8];
            vbus_pkg::REGION_PALETTE: rd_byte = pal_rdata_i[{rd_lane_r[0], 3'b000} +: 8];
            vbus_pkg::REGION_SPRITE:  rd_byte = spr_rdata_i[{rd_lane_r, 3'b000} +: 8];
            default:                  rd_byte = '0;   // unmapped reads as zero
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_r <= vbus_pkg::ST_IDLE;
        end else begin
            case (state_r)
                vbus_pkg::ST_IDLE: if (accept && !req_i.write) state_r <= vbus_pkg::ST_READ;
                vbus_pkg::ST_READ: state_r <= vbus_pkg::ST_RESP;
                vbus_pkg::ST_RESP: if (rsp_ready_i) state_r <= vbus_pkg::ST_IDLE;
                default:           state_r <= vbus_pkg::ST_IDLE;
            endcase
        end
    end

    // Pending read info and response byte
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_region_r <= region;
            rd_lane_r   <= lane_o;
        end
        if (state_r == vbus_pkg::ST_READ) begin
            rsp_data_r <= rd_byte;
        end
    end

    assign rsp_valid_o = (state_r == vbus_pkg::ST_RESP);
    assign rsp_data_o  = rsp_data_r;

endmodule

`default_nettype wire

//--- source/membus_arbiter.sv
`default_nettype none

module membus_arbiter (
    input  wire                           clk,
    input  wire                           reset,

    // Host commands from the register bus
    input  wire                           host_cmd_valid_i,
    input  wire vbus_pkg::mem_cmd_t       host_cmd_i,

    // Fetch requests
    input  wire                           lyr_fetch_valid_i,
    input  wire vbus_pkg::ram_word_addr_t lyr_fetch_addr_i,
    input  wire                           spr_fetch_valid_i,
    input  wire vbus_pkg::ram_word_addr_t spr_fetch_addr_i,

    input  wire vbus_pkg::word_t          mem_rdata_i,

    output logic                          lyr_fetch_ready_o,
    output logic                          spr_fetch_ready_o,
    output logic                          lyr_fetch_ack_o,
    output logic                          spr_fetch_ack_o,
    output vbus_pkg::word_t               fetch_data_o,
    output vbus_pkg::mem_cmd_t            mem_cmd_o
);

    logic lyr_grant;
    logic spr_grant;

    // Host always wins, then layer, then sprite
    assign lyr_fetch_ready_o = !host_cmd_valid_i;
    assign spr_fetch_ready_o = !host_cmd_valid_i && !lyr_fetch_valid_i;

    always_comb begin
        mem_cmd_o = '0;
        lyr_grant = 1'b0;
        spr_grant = 1'b0;
        if (host_cmd_valid_i) begin
            mem_cmd_o = host_cmd_i;
        end else if (lyr_fetch_valid_i) begin
            mem_cmd_o.addr = lyr_fetch_addr_i;
            lyr_grant      = 1'b1;
        end else if (spr_fetch_valid_i) begin
            mem_cmd_o.addr = spr_fetch_addr_i;
            spr_grant      = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Acks, one cycle after the grant
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lyr_fetch_ack_o <= 1'b0;
            spr_fetch_ack_o <= 1'b0;
        end else begin
            lyr_fetch_ack_o <= lyr_grant;
            spr_fetch_ack_o <= spr_grant;
        end
    end

    // Returned word only shown during an ack
    assign fetch_data_o = (lyr_fetch_ack_o || spr_fetch_ack_o) ? mem_rdata_i : '0;

endmodule

`default_nettype wire

//--- source/lane_ram.sv
`default_nettype none

module lane_ram #(
    parameter int LANES    = 2,
    parameter int IDX_BITS = 8
) (
    input  wire                        clk,

    // Host write and read-back
    input  wire                        we_i,
    input  wire [$clog2(LANES)-1:0]    lane_i,
    input  wire [IDX_BITS-1:0]         wr_idx_i,
    input  wire vbus_pkg::byte_t       wr_byte_i,
    output logic [LANES*8-1:0]         host_rdata_o,

    // Display read
    input  wire [IDX_BITS-1:0]         disp_idx_i,
    output logic [LANES*8-1:0]         disp_rdata_o
);

    logic [LANES-1:0][7:0] mem_r [0:(1 << IDX_BITS) - 1];

    initial begin
        for (int i = 0; i < (1 << IDX_BITS); i++) begin
            mem_r[i] = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // One write lane, two synchronous read ports
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_r[wr_idx_i][lane_i] <= wr_byte_i;
        end
        host_rdata_o <= mem_r[wr_idx_i];
        disp_rdata_o <= mem_r[disp_idx_i];
    end

endmodule

`default_nettype wire

//--- source/main_ram.sv
`default_nettype none

module main_ram (
    input  wire                     clk,
    input  wire vbus_pkg::mem_cmd_t cmd_i,
    output vbus_pkg::word_t         rdata_o
);

    // 32K x 32 bit, byte lanes
    logic [3:0][7:0] mem_r [0:(1 << $bits(vbus_pkg::ram_word_addr_t)) - 1];

    // Memory starts out cleared
    initial begin
        for (int i = 0; i < (1 << $bits(vbus_pkg::ram_word_addr_t)); i++) begin
            mem_r[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_i.write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (cmd_i.lanes[lane]) begin
                    mem_r[cmd_i.addr][lane] <= cmd_i.wdata[8*lane +: 8];
                end
            end
        end
        // Read-before-write on the same word
        rdata_o <= mem_r[cmd_i.addr];
    end

endmodule

`default_nettype wire

//--- source/vbus_pkg.sv
`default_nettype none

package vbus_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////
    typedef logic  [7:0] byte_t;
    typedef logic [31:0] word_t;
    typedef logic [18:0] reg_addr_t;
    typedef logic [14:0] ram_word_addr_t;   // 32K words
    typedef logic  [3:0] lane_sel_t;
    typedef logic  [7:0] pal_idx_t;
    typedef logic [15:0] pal_entry_t;       // 12-bit RGB in low bits
    typedef logic  [7:0] spr_idx_t;
    typedef logic [31:0] spr_attr_t;

    ////////////////////////////////////////////////////////////
    // Bus structs
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        reg_addr_t addr;
        byte_t     wdata;
        logic      write;
    } host_req_t;

    typedef struct packed {
        ram_word_addr_t addr;
        word_t          wdata;
        lane_sel_t      lanes;
        logic           write;
    } mem_cmd_t;

    typedef enum logic [1:0] {REGION_NONE, REGION_MAIN, REGION_PALETTE, REGION_SPRITE} region_e;
    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_RESP} ctrl_state_e;

    // Register bus memory map
    localparam int        MAIN_BASE_BIT = 18;
    localparam reg_addr_t PAL_BASE      = 19'h40200;
    localparam int        PAL_SPAN_BITS = 9;
    localparam reg_addr_t SPR_BASE      = 19'h40800;
    localparam int        SPR_SPAN_BITS = 10;
    localparam int        PAL_LANES     = 2;
    localparam int        SPR_LANES     = 4;

endpackage

`default_nettype wire
